// File: common/rvviTracer_config.svh
`ifndef RVVI_TRACER_CONFIG_SVH
`define RVVI_TRACER_CONFIG_SVH

// Core data word
`define RVVI_XLEN       32

// Lane order mstatus, misa, mie, mtvec, mscratch, mepc, mcause, mip
`define RVVI_NUM_CSR    8
`define RVVI_NUM_GPR    32
// Destination write ports per retirement
`define RVVI_NUM_RD     2

`define RVVI_APB_AW     12

// Tracked lines: MSI 3, MTI 7, MEI 11, local 16 to 31
`define RVVI_IRQ_MASK   32'hFFFF_0888

// Register map byte offsets
`define REG_CSR_BASE    12'h000
`define REG_CSR_WB      12'h040
`define REG_GPR_WB      12'h044
`define REG_LAST_PC     12'h048
`define REG_LAST_INSN   12'h04C
`define REG_ORDER       12'h050
`define REG_IRQ_CHG     12'h054
`define REG_GPR_BASE    12'h080

`endif

// File: common/rvviTracerPkg.sv
`default_nettype none

`include "rvviTracer_config.svh"

package rvviTracerPkg;

    // One data word of the core
    typedef logic [`RVVI_XLEN-1:0] word_t;

    //////////////////////////////////////////////////
    // Retirement record
    //////////////////////////////////////////////////

    // Per-CSR view from the core
    typedef struct packed {
        word_t rdata;
        word_t wdata;
        word_t wmask;
    } csrPort_t;

    // Destination register write
    typedef struct packed {
        logic       valid;
        logic [4:0] addr;
        word_t      data;
    } rdWrite_t;

    typedef struct packed {
        logic                          valid;
        logic [63:0]                   order;
        word_t                         insn;
        logic                          trap;
        logic                          intr;
        logic [1:0]                    mode;
        word_t                         pc;
        rdWrite_t [`RVVI_NUM_RD-1:0]   rd;
        csrPort_t [`RVVI_NUM_CSR-1:0]  csr;
    } retireRecord_t;

    // What one CSR lane sees
    typedef struct packed {
        logic     valid;
        csrPort_t csr;
    } laneIn_t;

    //////////////////////////////////////////////////
    // APB
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`RVVI_APB_AW-1:0] paddr;
        word_t                   pwdata;
    } apbReq_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr;
    } apbRsp_t;

endpackage

`default_nettype wire

// File: hw/retireCapture.sv
`default_nettype none

`include "rvviTracer_config.svh"

module retireCapture (
    input  logic                         rvvi,
    input  logic                         rstN_i,
    input  rvviTracerPkg::retireRecord_t retire_i,
    output rvviTracerPkg::laneIn_t       lane_o [`RVVI_NUM_CSR],
    output rvviTracerPkg::rdWrite_t      rd_o [`RVVI_NUM_RD],
    output logic                         retValid_o,
    output rvviTracerPkg::word_t         lastPc_o,
    output rvviTracerPkg::word_t         lastInsn_o,
    output logic [63:0]                  order_o
);
    import rvviTracerPkg::*;

    // Captured record payload
    retireRecord_t capRec;
    // Captured valid
    logic capValid;

    //////////////////////////////////////////////////
    // Capture stage
    //////////////////////////////////////////////////

    // Payload taken every edge, no back-pressure
    always_ff @(posedge rvvi) begin
        capRec <= retire_i;
    end

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            capValid <= 1'b0;
        end else begin
            capValid <= retire_i.valid;
        end
    end

    // Last retirement, updated one edge after capture
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            lastPc_o   <= '0;
            lastInsn_o <= '0;
            order_o    <= '0;
        end else if (capValid) begin
            lastPc_o   <= capRec.pc;
            lastInsn_o <= capRec.insn;
            order_o    <= capRec.order;
        end
    end

    //////////////////////////////////////////////////
    // Split towards lanes and shadow
    //////////////////////////////////////////////////

    // Every lane carries the captured valid
    for (genvar gLane = 0; gLane < `RVVI_NUM_CSR; gLane++) begin : gLaneSplit
        assign lane_o[gLane] = '{valid: capValid, csr: capRec.csr[gLane]};
    end

    for (genvar gRd = 0; gRd < `RVVI_NUM_RD; gRd++) begin : gRdSplit
        assign rd_o[gRd] = capRec.rd[gRd];
    end

    assign retValid_o = capValid;

endmodule

`default_nettype wire

// File: hw/csrTrack/csrLane.sv
`default_nettype none

`include "rvviTracer_config.svh"

module csrLane (
    input  logic                   rvvi,
    input  logic                   rstN_i,
    input  rvviTracerPkg::laneIn_t lane_i,
    output rvviTracerPkg::word_t   value_o,
    output logic                   written_o
);
    import rvviTracerPkg::*;

    // Merged CSR value of this retirement
    word_t merged;
    // Stored value and written flag
    word_t valueQ;
    logic  writtenQ;

    // Masked bits from write data
    // Remaining bits from read data
    assign merged = (lane_i.csr.wdata & lane_i.csr.wmask)
                  | (lane_i.csr.rdata & ~lane_i.csr.wmask);

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            valueQ   <= '0;
            writtenQ <= 1'b0;
        end else if (lane_i.valid) begin
            valueQ   <= merged;
            // Flag only a real change of the tracked value
            writtenQ <= (merged != valueQ);
        end
    end

    assign value_o   = valueQ;
    assign written_o = writtenQ;

endmodule

`default_nettype wire

// File: hw/gprShadow.sv
`default_nettype none

`include "rvviTracer_config.svh"

module gprShadow (
    input  logic                       rvvi,
    input  logic                       rstN_i,
    input  logic                       retValid_i,
    input  rvviTracerPkg::rdWrite_t    rd_i [`RVVI_NUM_RD],
    output rvviTracerPkg::word_t       gpr_o [`RVVI_NUM_GPR],
    output logic [`RVVI_NUM_GPR-1:0]   wbMask_o
);
    import rvviTracerPkg::*;

    // Shadow register file
    word_t regQ [`RVVI_NUM_GPR];
    // Next contents if this retirement is absorbed
    word_t nextVal [`RVVI_NUM_GPR];
    // Registers hit by this retirement
    logic [`RVVI_NUM_GPR-1:0] hitMask;
    logic [`RVVI_NUM_GPR-1:0] wbMaskQ;

    //////////////////////////////////////////////////
    // Write port merge
    //////////////////////////////////////////////////

    always_comb begin
        hitMask = '0;
        for (int r = 0; r < `RVVI_NUM_GPR; r++) begin
            nextVal[r] = regQ[r];
        end
        // Higher port applied last so port 1 wins
        // x0 writes dropped
        for (int p = 0; p < `RVVI_NUM_RD; p++) begin
            if (rd_i[p].valid && (rd_i[p].addr != 5'd0)) begin
                hitMask[rd_i[p].addr] = 1'b1;
                nextVal[rd_i[p].addr] = rd_i[p].data;
            end
        end
    end

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            for (int r = 0; r < `RVVI_NUM_GPR; r++) begin
                regQ[r] <= '0;
            end
            wbMaskQ <= '0;
        end else if (retValid_i) begin
            for (int r = 0; r < `RVVI_NUM_GPR; r++) begin
                regQ[r] <= nextVal[r];
            end
            // Mask reflects last valid retirement only
            wbMaskQ <= hitMask;
        end
    end

    assign gpr_o    = regQ;
    assign wbMask_o = wbMaskQ;

endmodule

`default_nettype wire

// File: hw/irqMonitor.sv
`default_nettype none

`include "rvviTracer_config.svh"

module irqMonitor (
    input  logic        rvvi,
    input  logic        rstN_i,
    input  logic [31:0] irq_i,
    input  logic [31:0] clear_i,
    output logic [31:0] changed_o
);

    // Previous sample of the lines
    logic [31:0] irqPrevQ;
    // Sticky change flags
    logic [31:0] changedQ;
    // Masked change seen at this edge
    logic [31:0] setMask;

    // Either direction counts as a change
    assign setMask = (irq_i ^ irqPrevQ) & `RVVI_IRQ_MASK;

    // Sampled every edge, reset included
    // So no false change on reset release
    always_ff @(posedge rvvi) begin
        irqPrevQ <= irq_i;
    end

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            changedQ <= '0;
        end else begin
            // Set applied after clear so set wins
            changedQ <= (changedQ & ~clear_i) | setMask;
        end
    end

    assign changed_o = changedQ;

endmodule

`default_nettype wire

// File: hw/apbRegs.sv
`default_nettype none

`include "rvviTracer_config.svh"

module apbRegs (
    input  logic                       rvvi,
    input  logic                       rstN_i,
    input  rvviTracerPkg::apbReq_t     apb_i,
    output rvviTracerPkg::apbRsp_t     apb_o,
    input  rvviTracerPkg::word_t       csrValue_i [`RVVI_NUM_CSR],
    input  logic [`RVVI_NUM_CSR-1:0]   csrWritten_i,
    input  rvviTracerPkg::word_t       gpr_i [`RVVI_NUM_GPR],
    input  rvviTracerPkg::word_t       wbMask_i,
    input  rvviTracerPkg::word_t       lastPc_i,
    input  rvviTracerPkg::word_t       lastInsn_i,
    input  logic [63:0]                order_i,
    input  logic [31:0]                irqChanged_i,
    output logic [31:0]                irqClear_o
);
    import rvviTracerPkg::*;

    localparam int CsrIdxW = $clog2(`RVVI_NUM_CSR);
    localparam int GprIdxW = $clog2(`RVVI_NUM_GPR);
    // Zero fill above the written flags
    localparam int PadW    = `RVVI_XLEN - `RVVI_NUM_CSR;

    logic                    access;
    logic                    hit;
    logic                    isIrq;
    logic                    err;
    word_t                   readData;
    logic [`RVVI_APB_AW-1:0] csrOff;
    logic [`RVVI_APB_AW-1:0] gprOff;
    logic [31:0]             clearQ;

    // Access phase, always ready
    assign access = apb_i.psel && apb_i.penable;

    assign csrOff = apb_i.paddr - `REG_CSR_BASE;
    assign gprOff = apb_i.paddr - `REG_GPR_BASE;

    //////////////////////////////////////////////////
    // Address decode and read mux
    //////////////////////////////////////////////////

    always_comb begin
        hit      = 1'b0;
        isIrq    = 1'b0;
        readData = '0;
        // Unaligned addresses fall outside the map
        if (apb_i.paddr[1:0] == 2'b00) begin
            if ((apb_i.paddr >= `REG_GPR_BASE) && (gprOff < 4 * `RVVI_NUM_GPR)) begin
                hit      = 1'b1;
                readData = gpr_i[gprOff[GprIdxW+1:2]];
            end else if ((apb_i.paddr >= `REG_CSR_BASE)
                         && (csrOff < 4 * `RVVI_NUM_CSR)) begin
                hit      = 1'b1;
                readData = csrValue_i[csrOff[CsrIdxW+1:2]];
            end else begin
                hit = 1'b1;
                case (apb_i.paddr)
                    `REG_CSR_WB:    readData = {{PadW{1'b0}}, csrWritten_i};
                    `REG_GPR_WB:    readData = wbMask_i;
                    `REG_LAST_PC:   readData = lastPc_i;
                    `REG_LAST_INSN: readData = lastInsn_i;
                    // Low word of the order only
                    `REG_ORDER:     readData = order_i[`RVVI_XLEN-1:0];
                    `REG_IRQ_CHG: begin
                        readData = irqChanged_i;
                        isIrq    = 1'b1;
                    end
                    default:        hit = 1'b0;
                endcase
            end
        end
    end

    // Unmapped, or write to a read-only register
    assign err = !hit || (apb_i.pwrite && !isIrq);

    always_comb begin
        apb_o.pready  = access;
        apb_o.pslverr = access && err;
        apb_o.prdata  = (access && !apb_i.pwrite && !err) ? readData : '0;
    end

    //////////////////////////////////////////////////
    // Interrupt flag clear
    //////////////////////////////////////////////////

    // One-cycle pulse after the write access
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            clearQ <= '0;
        end else if (access && apb_i.pwrite && isIrq) begin
            clearQ <= apb_i.pwdata;
        end else begin
            clearQ <= '0;
        end
    end

    assign irqClear_o = clearQ;

endmodule

`default_nettype wire

// File: hw/rvviTracer.sv
`default_nettype none

`include "rvviTracer_config.svh"

module rvviTracer (
    input  logic                         rvvi,
    input  logic                         rstN_i,
    input  rvviTracerPkg::retireRecord_t retire_i,
    input  logic [31:0]                  irq_i,
    input  rvviTracerPkg::apbReq_t       apb_i,
    output rvviTracerPkg::apbRsp_t       apb_o
);
    import rvviTracerPkg::*;

    // Capture stage outputs
    laneIn_t     laneIn [`RVVI_NUM_CSR];
    rdWrite_t    rdWrite [`RVVI_NUM_RD];
    logic        retValid;
    word_t       lastPc;
    word_t       lastInsn;
    logic [63:0] order;

    // Lane drain towards APB
    word_t                    csrValue [`RVVI_NUM_CSR];
    logic [`RVVI_NUM_CSR-1:0] csrWritten;

    // Shadow and interrupt state
    word_t                    gpr [`RVVI_NUM_GPR];
    logic [`RVVI_NUM_GPR-1:0] wbMask;
    logic [31:0]              irqChanged;
    logic [31:0]              irqClear;

    //////////////////////////////////////////////////
    // Retirement path
    //////////////////////////////////////////////////

    retireCapture u_retireCapture (
        .rvvi       (rvvi),
        .rstN_i     (rstN_i),
        .retire_i   (retire_i),
        .lane_o     (laneIn),
        .rd_o       (rdWrite),
        .retValid_o (retValid),
        .lastPc_o   (lastPc),
        .lastInsn_o (lastInsn),
        .order_o    (order)
    );

    // One lane per tracked CSR
    for (genvar gLane = 0; gLane < `RVVI_NUM_CSR; gLane++) begin : gCsrLane
        csrLane u_csrLane (
            .rvvi      (rvvi),
            .rstN_i    (rstN_i),
            .lane_i    (laneIn[gLane]),
            .value_o   (csrValue[gLane]),
            .written_o (csrWritten[gLane])
        );
    end

    gprShadow u_gprShadow (
        .rvvi       (rvvi),
        .rstN_i     (rstN_i),
        .retValid_i (retValid),
        .rd_i       (rdWrite),
        .gpr_o      (gpr),
        .wbMask_o   (wbMask)
    );

    //////////////////////////////////////////////////
    // Interrupts and software access
    //////////////////////////////////////////////////

    irqMonitor u_irqMonitor (
        .rvvi      (rvvi),
        .rstN_i    (rstN_i),
        .irq_i     (irq_i),
        .clear_i   (irqClear),
        .changed_o (irqChanged)
    );

    apbRegs u_apbRegs (
        .rvvi         (rvvi),
        .rstN_i       (rstN_i),
        .apb_i        (apb_i),
        .apb_o        (apb_o),
        .csrValue_i   (csrValue),
        .csrWritten_i (csrWritten),
        .gpr_i        (gpr),
        .wbMask_i     (wbMask),
        .lastPc_i     (lastPc),
        .lastInsn_i   (lastInsn),
        .order_i      (order),
        .irqChanged_i (irqChanged),
        .irqClear_o   (irqClear)
    );

endmodule

`default_nettype wire

// File: dv/tb_rvviTracer.sv
`default_nettype none

`include "rvviTracer_config.svh"

module tb_rvviTracer;
    import rvviTracerPkg::*;

    localparam int ClkPeriod   = 100;
    localparam int ResetCycles = 10;
    // Access phase cycles allowed before giving up
    localparam int ApbTimeout  = 20;

    logic          rvvi;
    logic          rstN;
    retireRecord_t retire;
    logic [31:0]   irq;
    apbReq_t       apbReq;
    apbRsp_t       apbRsp;

    integer seed;
    int     errCount;
    int     checkCount;
    int     testCount;
    int     testErrStart;

    // Reference model state
    word_t                    mCsr [`RVVI_NUM_CSR];
    logic [`RVVI_NUM_CSR-1:0] mWritten;
    word_t                    mGpr [`RVVI_NUM_GPR];
    logic [`RVVI_NUM_GPR-1:0] mWbMask;
    word_t                    mPc;
    word_t                    mInsn;
    logic [63:0]              mOrder;
    logic [31:0]              mIrqChg;

    rvviTracer u_dut (
        .rvvi     (rvvi),
        .rstN_i   (rstN),
        .retire_i (retire),
        .irq_i    (irq),
        .apb_i    (apbReq),
        .apb_o    (apbRsp)
    );

    initial begin
        rvvi = 1'b0;
        forever #(ClkPeriod / 2) rvvi = ~rvvi;
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkFlags(input string name, input logic [`RVVI_NUM_CSR-1:0] exp,
                              input logic [`RVVI_NUM_CSR-1:0] act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic checkMask(input string name, input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Error response must also read as zero
    task automatic checkErr(input string name, input logic exp, input apbRsp_t rsp);
        checkCount++;
        if (rsp.pslverr !== exp) begin
            errCount++;
            $display("[FAIL] %s pslverr expected %b actual %b", name, exp, rsp.pslverr);
        end else if (exp && (rsp.prdata !== '0)) begin
            errCount++;
            $display("[FAIL] %s error data expected %h actual %h", name, 32'h0, rsp.prdata);
        end
    endtask

    //////////////////////////////////////////////////
    // Model helpers
    //////////////////////////////////////////////////

    function automatic word_t randWord();
        return $random(seed);
    endfunction

    function automatic logic isMapped(input logic [`RVVI_APB_AW-1:0] addr);
        if (addr[1:0] != 2'b00) return 1'b0;
        if (addr < `REG_CSR_BASE + 4 * `RVVI_NUM_CSR) return 1'b1;
        if ((addr >= `REG_GPR_BASE) && (addr < `REG_GPR_BASE + 4 * `RVVI_NUM_GPR)) return 1'b1;
        return (addr >= `REG_CSR_WB) && (addr <= `REG_IRQ_CHG);
    endfunction

    // Expected read data per register map
    function automatic word_t modelRead(input logic [`RVVI_APB_AW-1:0] addr);
        if (!isMapped(addr)) return '0;
        if (addr < `REG_CSR_BASE + 4 * `RVVI_NUM_CSR) return mCsr[addr[4:2]];
        if (addr >= `REG_GPR_BASE) return mGpr[addr[6:2]];
        case (addr)
            `REG_CSR_WB:    return word_t'(mWritten);
            `REG_GPR_WB:    return mWbMask;
            `REG_LAST_PC:   return mPc;
            `REG_LAST_INSN: return mInsn;
            `REG_ORDER:     return mOrder[31:0];
            default:        return mIrqChg;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Random record on the falling edge, model follows in retirement order
    task automatic driveRetire(input logic valid);
        word_t r;
        word_t merged;
        @(negedge rvvi);
        r = randWord();
        retire.valid = valid;
        retire.order = {randWord(), randWord()};
        retire.insn  = randWord();
        retire.pc    = randWord();
        retire.trap  = r[0];
        retire.intr  = r[1];
        retire.mode  = r[3:2];
        for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            r = randWord();
            retire.csr[i].rdata = randWord();
            retire.csr[i].wdata = randWord();
            retire.csr[i].wmask = randWord() & randWord();
            // Quiet lane, value must not move
            if (r[0]) begin
                retire.csr[i].rdata = mCsr[i];
                retire.csr[i].wdata = mCsr[i];
            end
        end
        for (int p = 0; p < `RVVI_NUM_RD; p++) begin
            r = randWord();
            retire.rd[p].valid = r[0];
            retire.rd[p].addr  = (r[3:1] == 3'd0) ? 5'd0 : r[8:4];
            retire.rd[p].data  = randWord();
        end
        r = randWord();
        // Both ports on one register now and then
        if (r[1:0] == 2'b00) begin
            retire.rd[1].addr = retire.rd[0].addr;
        end
        if (valid) begin
            mWbMask = '0;
            for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
                // Bit by bit, mask set picks write data
                for (int b = 0; b < `RVVI_XLEN; b++) begin
                    if (retire.csr[i].wmask[b]) begin
                        merged[b] = retire.csr[i].wdata[b];
                    end else begin
                        merged[b] = retire.csr[i].rdata[b];
                    end
                end
                mWritten[i] = (merged != mCsr[i]);
                mCsr[i]     = merged;
            end
            // Later port overrides, x0 stays zero
            for (int p = 0; p < `RVVI_NUM_RD; p++) begin
                if (retire.rd[p].valid && (retire.rd[p].addr != 5'd0)) begin
                    mGpr[retire.rd[p].addr]    = retire.rd[p].data;
                    mWbMask[retire.rd[p].addr] = 1'b1;
                end
            end
            mPc    = retire.pc;
            mInsn  = retire.insn;
            mOrder = retire.order;
        end
    endtask

    // Idle record, then the fixed two-edge latency
    task automatic settle();
        driveRetire(1'b0);
        repeat (2) @(posedge rvvi);
    endtask

    // Back-to-back records, first one always valid
    task automatic retireBurst();
        word_t r;
        r = randWord();
        for (int b = 0; b <= r[1:0]; b++) begin
            driveRetire((b == 0) || r[4 + b]);
        end
        settle();
    endtask

    task automatic apbAccess(input logic write, input logic [`RVVI_APB_AW-1:0] addr,
                             input word_t wdata, output apbRsp_t rsp);
        int   waitCycles;
        logic gotReady;
        rsp        = '0;
        gotReady   = 1'b0;
        waitCycles = 0;
        @(negedge rvvi);
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        // Setup phase never ready
        #(ClkPeriod / 4);
        if (apbRsp.pready !== 1'b0) begin
            errCount++;
            $display("APB setup phase to address %h shows pready high", addr);
        end
        @(negedge rvvi);
        apbReq.penable = 1'b1;
        // Sample a quarter period after the drive edge
        while (!gotReady && (waitCycles < ApbTimeout)) begin
            #(ClkPeriod / 4);
            if (apbRsp.pready) begin
                gotReady = 1'b1;
                rsp      = apbRsp;
            end else begin
                waitCycles++;
                @(negedge rvvi);
            end
        end
        if (!gotReady) begin
            errCount++;
            $display("APB access to address %h timed out waiting for pready", addr);
        end else if (waitCycles != 0) begin
            errCount++;
            $display("APB access to address %h took %0d extra wait cycles", addr, waitCycles);
        end
        @(negedge rvvi);
        apbReq = '0;
    endtask

    task automatic expectRead(input string name, input logic [`RVVI_APB_AW-1:0] addr);
        apbRsp_t rsp;
        string   tag;
        tag = $sformatf("%s @%h", name, addr);
        apbAccess(1'b0, addr, '0, rsp);
        checkErr(tag, !isMapped(addr), rsp);
        checkWord(tag, modelRead(addr), rsp.prdata);
    endtask

    task automatic readFlags(input string name);
        apbRsp_t rsp;
        apbAccess(1'b0, `REG_CSR_WB, '0, rsp);
        checkErr(name, 1'b0, rsp);
        checkFlags(name, mWritten, rsp.prdata[`RVVI_NUM_CSR-1:0]);
    endtask

    task automatic readMask(input string name, input logic [`RVVI_APB_AW-1:0] addr,
                            input logic [31:0] exp);
        apbRsp_t rsp;
        apbAccess(1'b0, addr, '0, rsp);
        checkErr(name, 1'b0, rsp);
        checkMask(name, exp, rsp.prdata);
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errCount == testErrStart) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errCount - testErrStart);
        end
        testErrStart = errCount;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        apbRsp_t                 rsp;
        word_t                   bits;
        word_t                   mix;
        logic [`RVVI_APB_AW-1:0] addr;
        seed         = 32'h68c8_fcda;
        errCount     = 0;
        checkCount   = 0;
        testCount    = 0;
        testErrStart = 0;
        rstN         = 1'b0;
        retire       = '0;
        irq          = '0;
        apbReq       = '0;
        for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            mCsr[i] = '0;
        end
        for (int r = 0; r < `RVVI_NUM_GPR; r++) begin
            mGpr[r] = '0;
        end
        mWritten = '0;
        mWbMask  = '0;
        mPc      = '0;
        mInsn    = '0;
        mOrder   = '0;
        mIrqChg  = '0;
        repeat (ResetCycles) @(negedge rvvi);
        rstN = 1'b1;

        // Lane values after each retirement
        for (int n = 0; n < 200; n++) begin
            driveRetire(1'b1);
            bits = randWord();
            repeat (bits[1:0]) driveRetire(1'b0);
            settle();
            for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
                expectRead("csrMerge", `REG_CSR_BASE + 4 * i);
            end
        end
        finishTest("csrMerge");

        // Flags follow the last valid record only
        for (int n = 0; n < 40; n++) begin
            driveRetire(1'b1);
            settle();
            readFlags("writtenFlags");
            bits = randWord();
            repeat (bits[2:0] + 1) driveRetire(1'b0);
            settle();
            readFlags("writtenFlagsHold");
        end
        finishTest("writtenFlags");

        for (int n = 0; n < 30; n++) begin
            retireBurst();
            for (int r = 0; r < `RVVI_NUM_GPR; r++) begin
                expectRead("gprShadow", `REG_GPR_BASE + 4 * r);
            end
            readMask("gprWbMask", `REG_GPR_WB, mWbMask);
        end
        finishTest("gprShadow");

        for (int n = 0; n < 30; n++) begin
            retireBurst();
            expectRead("lastPc", `REG_LAST_PC);
            expectRead("lastInsn", `REG_LAST_INSN);
            expectRead("order", `REG_ORDER);
        end
        finishTest("lastRetire");

        // Sparse toggles, lines in and out of the mask
        for (int n = 0; n < 40; n++) begin
            bits = randWord();
            repeat (bits[1:0] + 1) begin
                @(negedge rvvi);
                mix     = randWord() & randWord() & randWord();
                mIrqChg = mIrqChg | (mix & `RVVI_IRQ_MASK);
                irq     = irq ^ mix;
            end
            readMask("irqFlags", `REG_IRQ_CHG, mIrqChg);
            if (bits[4]) begin
                mix = randWord();
                apbAccess(1'b1, `REG_IRQ_CHG, mix, rsp);
                checkErr("irqClear", 1'b0, rsp);
                mIrqChg = mIrqChg & ~mix;
                readMask("irqClear", `REG_IRQ_CHG, mIrqChg);
            end
        end
        finishTest("irqFlags");

        // Random addresses, mostly outside the map or unaligned
        for (int n = 0; n < 60; n++) begin
            bits = randWord();
            expectRead("apbRead", bits[11:0]);
        end
        for (int n = 0; n < 30; n++) begin
            bits = randWord();
            addr = bits[11:0] & 12'h0FC;
            if (addr == `REG_IRQ_CHG) begin
                addr = `REG_LAST_PC;
            end
            apbAccess(1'b1, addr, randWord(), rsp);
            checkErr($sformatf("roWrite @%h", addr), 1'b1, rsp);
        end
        // Whole map unchanged after the rejected writes
        for (int a = `REG_CSR_BASE; a < `REG_CSR_BASE + 4 * `RVVI_NUM_CSR; a += 4) begin
            expectRead("mapSweep", a);
        end
        for (int a = `REG_CSR_WB; a <= `REG_IRQ_CHG; a += 4) begin
            expectRead("mapSweep", a);
        end
        for (int a = `REG_GPR_BASE; a < `REG_GPR_BASE + 4 * `RVVI_NUM_GPR; a += 4) begin
            expectRead("mapSweep", a);
        end
        finishTest("apbErrors");

        $display("Tests: %0d  checks: %0d  errors: %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rvviTracer.f
+incdir+common
common/rvviTracerPkg.sv
hw/retireCapture.sv
hw/csrTrack/csrLane.sv
hw/gprShadow.sv
hw/irqMonitor.sv
hw/apbRegs.sv
hw/rvviTracer.sv
dv/tb_rvviTracer.sv
